/* csr_params.svh */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define XLEN       32
`define CSR_ADDR_W 12

// machine level csr numbers
`define MSTATUS_ADDR  12'h300
`define MEDELEG_ADDR  12'h302
`define MIE_ADDR      12'h304
`define MTVEC_ADDR    12'h305
`define MSCRATCH_ADDR 12'h340
`define MEPC_ADDR     12'h341
`define MCAUSE_ADDR   12'h342
`define MTVAL_ADDR    12'h343

// supervisor level csr numbers
`define SSTATUS_ADDR  12'h100
`define STVEC_ADDR    12'h105
`define SSCRATCH_ADDR 12'h140
`define SEPC_ADDR     12'h141
`define SCAUSE_ADDR   12'h142
`define STVAL_ADDR    12'h143

// writable bits
`define MSTATUS_MASK 32'h0004_19AA  // mie sie mpie spie spp mpp sum
`define SSTATUS_MASK 32'h0004_0122  // sie spie spp sum
`define TVEC_MASK    32'hFFFF_FFFC  // direct mode only
`define EPC_MASK     32'hFFFF_FFFC
`define CAUSE_MASK   32'h8000_001F

// mstatus field positions
`define MSTATUS_SIE    1
`define MSTATUS_MIE    3
`define MSTATUS_SPIE   5
`define MSTATUS_MPIE   7
`define MSTATUS_SPP    8
`define MSTATUS_MPP_LO 11  // two bits wide
`define MSTATUS_SUM    18

// exception codes
`define CAUSE_NONE             5'd31  // no trap this cycle
`define CAUSE_ILLEGAL_INST     5'd2
`define CAUSE_ECALL_U          5'd8
`define CAUSE_ECALL_S          5'd9
`define CAUSE_ECALL_M          5'd11
`define CAUSE_LOAD_PAGE_FAULT  5'd13
`define CAUSE_STORE_PAGE_FAULT 5'd15

`endif

/* csr_pkg.sv */
`default_nettype none

`include "csr_params.svh"

package csr_pkg;

    // privilege levels, encoding as in mstatus.mpp
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_t;

    typedef logic [`XLEN-1:0] word_t;

    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    typedef logic [4:0] cause_t;  // exception code, no interrupt bit

endpackage

`default_nettype wire

/* csr_bus_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csr_bus_port
    import csr_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      cyc,
    input  wire logic      stb,
    input  wire logic      we,
    input  csr_addr_t      adr,
    input  word_t          dat_w,
    input  priv_t          priv,
    input  word_t          rd_data,
    output logic           ack,
    output logic           err,
    output word_t          dat_r,
    output logic           acc_we,
    output csr_addr_t      acc_addr,
    output word_t          acc_wdata
);

    logic req_new;
    logic priv_fail;

    // request seen and not yet answered
    assign req_new = cyc && stb && !ack && !err;

    // csr number bits 9:8 give the lowest privilege allowed
    assign priv_fail = adr[9:8] > priv;

    assign acc_we    = req_new && we && !priv_fail;  // lands with the ack edge
    assign acc_addr  = adr;
    assign acc_wdata = dat_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            err <= 1'b0;
        end else begin
            ack <= req_new && !priv_fail;
            err <= req_new && priv_fail;
        end
    end

    // read data sampled with the request
    always_ff @(posedge clk) begin
        if (req_new) begin
            dat_r <= priv_fail ? '0 : rd_data;
        end
    end

    a_resp_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(ack && err));

endmodule

`default_nettype wire

/* csr_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csr_regs
    import csr_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic acc_we,
    input  csr_addr_t acc_addr,
    input  word_t     acc_wdata,
    input  wire logic enter_m,
    input  wire logic enter_s,
    input  wire logic ret_m,
    input  wire logic ret_s,
    input  priv_t     prev_priv,
    input  cause_t    cause,
    input  word_t     epc,
    input  word_t     tval,
    output word_t     rd_data,
    output word_t     mstatus,
    output word_t     medeleg,
    output word_t     mtvec,
    output word_t     stvec,
    output word_t     mepc,
    output word_t     sepc
);

    word_t mie;
    word_t mscratch;
    word_t mcause;
    word_t mtval;
    word_t sscratch;
    word_t scause;
    word_t stval;
    word_t mstatus_nxt;
    word_t cause_word;

    function automatic word_t merge(input word_t old, input word_t wdata, input word_t mask);
        merge = (old & ~mask) | (wdata & mask);
    endfunction

    assign cause_word = {{(`XLEN-5){1'b0}}, cause};

    // read mux, sstatus is a window on mstatus
    always_comb begin
        case (acc_addr)
            `MSTATUS_ADDR:  rd_data = mstatus;
            `SSTATUS_ADDR:  rd_data = mstatus & `SSTATUS_MASK;
            `MEDELEG_ADDR:  rd_data = medeleg;
            `MIE_ADDR:      rd_data = mie;
            `MTVEC_ADDR:    rd_data = mtvec;
            `MSCRATCH_ADDR: rd_data = mscratch;
            `MEPC_ADDR:     rd_data = mepc;
            `MCAUSE_ADDR:   rd_data = mcause;
            `MTVAL_ADDR:    rd_data = mtval;
            `STVEC_ADDR:    rd_data = stvec;
            `SSCRATCH_ADDR: rd_data = sscratch;
            `SEPC_ADDR:     rd_data = sepc;
            `SCAUSE_ADDR:   rd_data = scause;
            `STVAL_ADDR:    rd_data = stval;
            default:        rd_data = '0;  // unknown csr
        endcase
    end

    // mstatus: bus write first, then the trap stack fields on top
    always_comb begin
        mstatus_nxt = mstatus;
        if (acc_we && acc_addr == `MSTATUS_ADDR) begin
            mstatus_nxt = merge(mstatus, acc_wdata, `MSTATUS_MASK);
        end else if (acc_we && acc_addr == `SSTATUS_ADDR) begin
            mstatus_nxt = merge(mstatus, acc_wdata, `SSTATUS_MASK);
        end
        if (enter_m) begin
            mstatus_nxt[`MSTATUS_MPIE]       = mstatus[`MSTATUS_MIE];
            mstatus_nxt[`MSTATUS_MIE]        = 1'b0;
            mstatus_nxt[`MSTATUS_MPP_LO +: 2] = prev_priv;
        end else if (enter_s) begin
            mstatus_nxt[`MSTATUS_SPIE] = mstatus[`MSTATUS_SIE];
            mstatus_nxt[`MSTATUS_SIE]  = 1'b0;
            mstatus_nxt[`MSTATUS_SPP]  = prev_priv[0];  // u or s only
        end else if (ret_m) begin
            mstatus_nxt[`MSTATUS_MIE]        = mstatus[`MSTATUS_MPIE];
            mstatus_nxt[`MSTATUS_MPIE]       = 1'b1;
            mstatus_nxt[`MSTATUS_MPP_LO +: 2] = 2'b00;
        end else if (ret_s) begin
            mstatus_nxt[`MSTATUS_SIE]  = mstatus[`MSTATUS_SPIE];
            mstatus_nxt[`MSTATUS_SPIE] = 1'b1;
            mstatus_nxt[`MSTATUS_SPP]  = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus  <= '0;
            medeleg  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            stvec    <= '0;
            sscratch <= '0;
            sepc     <= '0;
            scause   <= '0;
            stval    <= '0;
        end else begin
            mstatus <= mstatus_nxt;
            if (acc_we) begin
                case (acc_addr)
                    `MEDELEG_ADDR:  medeleg  <= acc_wdata;
                    `MIE_ADDR:      mie      <= acc_wdata;
                    `MTVEC_ADDR:    mtvec    <= merge(mtvec, acc_wdata, `TVEC_MASK);
                    `MSCRATCH_ADDR: mscratch <= acc_wdata;
                    `MEPC_ADDR:     mepc     <= merge(mepc, acc_wdata, `EPC_MASK);
                    `MCAUSE_ADDR:   mcause   <= merge(mcause, acc_wdata, `CAUSE_MASK);
                    `MTVAL_ADDR:    mtval    <= acc_wdata;
                    `STVEC_ADDR:    stvec    <= merge(stvec, acc_wdata, `TVEC_MASK);
                    `SSCRATCH_ADDR: sscratch <= acc_wdata;
                    `SEPC_ADDR:     sepc     <= merge(sepc, acc_wdata, `EPC_MASK);
                    `SCAUSE_ADDR:   scause   <= merge(scause, acc_wdata, `CAUSE_MASK);
                    `STVAL_ADDR:    stval    <= acc_wdata;
                    default: ;
                endcase
            end
            // later assignments win over a colliding bus write
            if (enter_m) begin
                mepc   <= epc & `EPC_MASK;
                mcause <= cause_word;
                mtval  <= tval;
            end
            if (enter_s) begin
                sepc   <= epc & `EPC_MASK;
                scause <= cause_word;
                stval  <= tval;
            end
        end
    end

    // trap unit must never request two stack updates at once
    a_one_update: assert property (@(posedge clk) disable iff (rst)
        $onehot0({enter_m, enter_s, ret_m, ret_s}));

endmodule

`default_nettype wire

/* trap_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module trap_unit
    import csr_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic trap_valid,
    input  cause_t    trap_cause,
    input  word_t     trap_pc,
    input  word_t     trap_tval_in,
    input  wire logic ecall,
    input  wire logic mret,
    input  wire logic sret,
    input  word_t     mstatus,
    input  word_t     medeleg,
    input  word_t     mtvec,
    input  word_t     stvec,
    input  word_t     mepc,
    input  word_t     sepc,
    output priv_t     priv,
    output logic      enter_m,
    output logic      enter_s,
    output logic      ret_m,
    output logic      ret_s,
    output priv_t     prev_priv,
    output cause_t    cause,
    output word_t     epc,
    output word_t     tval,
    output logic      redirect_valid,
    output word_t     redirect_pc
);

    cause_t ecall_cause;
    logic   is_trap;
    logic   deleg;
    priv_t  priv_nxt;
    word_t  target;

    // ecall code follows the privilege it was issued from
    always_comb begin
        case (priv)
            PRIV_U:  ecall_cause = `CAUSE_ECALL_U;
            PRIV_S:  ecall_cause = `CAUSE_ECALL_S;
            default: ecall_cause = `CAUSE_ECALL_M;
        endcase
    end

    assign is_trap = ecall || (trap_valid && trap_cause != `CAUSE_NONE);
    assign cause   = ecall ? ecall_cause : trap_cause;

    // medeleg never delegates traps taken in m mode
    assign deleg = medeleg[cause] && priv != PRIV_M;

    assign enter_m = is_trap && !deleg;
    assign enter_s = is_trap && deleg;
    assign ret_m   = !is_trap && mret;
    assign ret_s   = !is_trap && !mret && sret;

    assign prev_priv = priv;
    assign epc       = trap_pc;

    always_comb begin
        case (cause)
            `CAUSE_ECALL_U, `CAUSE_ECALL_S, `CAUSE_ECALL_M:
                tval = '0;
            `CAUSE_ILLEGAL_INST, `CAUSE_LOAD_PAGE_FAULT, `CAUSE_STORE_PAGE_FAULT:
                tval = trap_tval_in;  // instruction bits or fault address
            default:
                tval = trap_pc;
        endcase
    end

    always_comb begin
        priv_nxt = priv;
        target   = sepc;
        if (enter_m) begin
            priv_nxt = PRIV_M;
            target   = mtvec & `TVEC_MASK;
        end else if (enter_s) begin
            priv_nxt = PRIV_S;
            target   = stvec & `TVEC_MASK;
        end else if (ret_m) begin
            priv_nxt = priv_t'(mstatus[`MSTATUS_MPP_LO +: 2]);
            target   = mepc;
        end else if (ret_s) begin
            priv_nxt = priv_t'({1'b0, mstatus[`MSTATUS_SPP]});
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv           <= PRIV_M;
            redirect_valid <= 1'b0;
        end else begin
            priv           <= priv_nxt;
            redirect_valid <= enter_m || enter_s || ret_m || ret_s;
        end
    end

    always_ff @(posedge clk) begin
        redirect_pc <= target;  // only meaningful with redirect_valid
    end

    // core contract on the event strobes
    a_event_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({trap_valid, ecall, mret, sret}));

endmodule

`default_nettype wire

/* csr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_top
    import csr_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    // wishbone classic slave
    input  wire logic cyc,
    input  wire logic stb,
    input  wire logic we,
    input  csr_addr_t adr,
    input  word_t     dat_w,
    output word_t     dat_r,
    output logic      ack,
    output logic      err,
    // core events
    input  wire logic trap_valid,
    input  cause_t    trap_cause,
    input  word_t     trap_pc,
    input  word_t     trap_tval_in,
    input  wire logic ecall,
    input  wire logic mret,
    input  wire logic sret,
    output logic      redirect_valid,
    output word_t     redirect_pc,
    output priv_t     priv,
    output word_t     status
);

    logic      acc_we;
    csr_addr_t acc_addr;
    word_t     acc_wdata;
    word_t     rd_data;
    logic      enter_m;
    logic      enter_s;
    logic      ret_m;
    logic      ret_s;
    priv_t     prev_priv;
    cause_t    cause;
    word_t     epc;
    word_t     tval;
    word_t     medeleg;
    word_t     mtvec;
    word_t     stvec;
    word_t     mepc;
    word_t     sepc;

    csr_bus_port u_bus_port (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .priv      (priv),
        .rd_data   (rd_data),
        .ack       (ack),
        .err       (err),
        .dat_r     (dat_r),
        .acc_we    (acc_we),
        .acc_addr  (acc_addr),
        .acc_wdata (acc_wdata)
    );

    csr_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .acc_we    (acc_we),
        .acc_addr  (acc_addr),
        .acc_wdata (acc_wdata),
        .enter_m   (enter_m),
        .enter_s   (enter_s),
        .ret_m     (ret_m),
        .ret_s     (ret_s),
        .prev_priv (prev_priv),
        .cause     (cause),
        .epc       (epc),
        .tval      (tval),
        .rd_data   (rd_data),
        .mstatus   (status),  // raw mstatus goes straight out
        .medeleg   (medeleg),
        .mtvec     (mtvec),
        .stvec     (stvec),
        .mepc      (mepc),
        .sepc      (sepc)
    );

    trap_unit u_trap (
        .clk            (clk),
        .rst            (rst),
        .trap_valid     (trap_valid),
        .trap_cause     (trap_cause),
        .trap_pc        (trap_pc),
        .trap_tval_in   (trap_tval_in),
        .ecall          (ecall),
        .mret           (mret),
        .sret           (sret),
        .mstatus        (status),
        .medeleg        (medeleg),
        .mtvec          (mtvec),
        .stvec          (stvec),
        .mepc           (mepc),
        .sepc           (sepc),
        .priv           (priv),
        .enter_m        (enter_m),
        .enter_s        (enter_s),
        .ret_m          (ret_m),
        .ret_s          (ret_s),
        .prev_priv      (prev_priv),
        .cause          (cause),
        .epc            (epc),
        .tval           (tval),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

/* tb_csr_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module tb_csr_top
    import csr_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int BUS_TIMEOUT     = 16;  // cycles to wait for ack or err

    localparam int EV_TRAP  = 0;
    localparam int EV_ECALL = 1;
    localparam int EV_MRET  = 2;
    localparam int EV_SRET  = 3;

    logic      clk;
    logic      rst;
    logic      cyc;
    logic      stb;
    logic      we;
    csr_addr_t adr;
    word_t     dat_w;
    word_t     dat_r;
    logic      ack;
    logic      err;
    logic      trap_valid;
    cause_t    trap_cause;
    word_t     trap_pc;
    word_t     trap_tval_in;
    logic      ecall;
    logic      mret;
    logic      sret;
    logic      redirect_valid;
    word_t     redirect_pc;
    priv_t     priv;
    word_t     status;

    logic [31:0] lfsr_state;
    int          errors;
    int          test_start_errors;
    int          tests_run;
    int          tests_failed;
    word_t       mtvec_exp;  // set by machine_trap, reused later

    csr_top UUT (
        .clk            (clk),
        .rst            (rst),
        .cyc            (cyc),
        .stb            (stb),
        .we             (we),
        .adr            (adr),
        .dat_w          (dat_w),
        .dat_r          (dat_r),
        .ack            (ack),
        .err            (err),
        .trap_valid     (trap_valid),
        .trap_cause     (trap_cause),
        .trap_pc        (trap_pc),
        .trap_tval_in   (trap_tval_in),
        .ecall          (ecall),
        .mret           (mret),
        .sret           (sret),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .priv           (priv),
        .status         (status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run length bounded by the test count
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog expired after %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
        $display("Done: errors found");
        $finish;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        int    i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[`XLEN-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        rand_bits = r;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_priv(input priv_t exp);
        @(negedge clk);
        if (priv !== exp) begin
            $display("mismatch priv: got %h expected %h", priv, exp);
            errors++;
        end
    endtask

    // one wishbone classic cycle, held until ack or err
    task automatic bus_access(input logic write, input csr_addr_t addr, input word_t wdata,
                              output word_t rdata, output logic got_ack, output logic got_err);
        int waited;
        waited = 0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= addr;
        dat_w <= wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && !err && waited < BUS_TIMEOUT);
        got_ack = ack;
        got_err = err;
        rdata   = dat_r;
        if (!ack && !err) begin
            $display("bus access to csr %h got no response", addr);
            errors++;
        end
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_write(input csr_addr_t addr, input word_t data);
        word_t rd;
        logic  got_ack;
        logic  got_err;
        bus_access(1'b1, addr, data, rd, got_ack, got_err);
        if (got_err) begin
            $display("write to csr %h was answered with err", addr);
            errors++;
        end
    endtask

    task automatic wb_read(input csr_addr_t addr, output word_t data);
        logic got_ack;
        logic got_err;
        bus_access(1'b0, addr, '0, data, got_ack, got_err);
        if (got_err) begin
            $display("read of csr %h was answered with err", addr);
            errors++;
        end
    endtask

    task automatic check_rw(input string name, input csr_addr_t addr, input word_t mask);
        word_t data;
        word_t rd;
        wb_read(addr, rd);
        check_word({name, " after reset"}, rd, '0);
        data = rand_bits(`XLEN);
        wb_write(addr, data);
        wb_read(addr, rd);
        check_word(name, rd, data & mask);
    endtask

    // strobe for one cycle, redirect is due one cycle later
    task automatic raise_event(input int kind, input cause_t c, input word_t pc,
                               input word_t tv, input word_t exp_pc);
        @(posedge clk);
        case (kind)
            EV_TRAP:  trap_valid <= 1'b1;
            EV_ECALL: ecall      <= 1'b1;
            EV_MRET:  mret       <= 1'b1;
            EV_SRET:  sret       <= 1'b1;
            default:  ;
        endcase
        trap_cause   <= c;
        trap_pc      <= pc;
        trap_tval_in <= tv;
        @(posedge clk);
        trap_valid <= 1'b0;
        ecall      <= 1'b0;
        mret       <= 1'b0;
        sret       <= 1'b0;
        @(negedge clk);
        if (redirect_valid !== 1'b1) begin
            $display("no redirect one cycle after event kind %0d", kind);
            errors++;
        end
        check_word("redirect_pc", redirect_pc, exp_pc);
        @(negedge clk);
        if (redirect_valid !== 1'b0) begin
            $display("redirect held longer than one cycle after event kind %0d", kind);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - test_start_errors);
        end
    endtask

    task automatic reset_and_rw();
        test_start_errors = errors;
        check_priv(PRIV_M);
        check_word("status after reset", status, '0);
        check_rw("mstatus",  `MSTATUS_ADDR,  `MSTATUS_MASK);
        check_rw("medeleg",  `MEDELEG_ADDR,  32'hFFFF_FFFF);
        check_rw("mie",      `MIE_ADDR,      32'hFFFF_FFFF);
        check_rw("mtvec",    `MTVEC_ADDR,    `TVEC_MASK);
        check_rw("mscratch", `MSCRATCH_ADDR, 32'hFFFF_FFFF);
        check_rw("mepc",     `MEPC_ADDR,     `EPC_MASK);
        check_rw("mcause",   `MCAUSE_ADDR,   `CAUSE_MASK);
        check_rw("mtval",    `MTVAL_ADDR,    32'hFFFF_FFFF);
        check_rw("stvec",    `STVEC_ADDR,    `TVEC_MASK);
        check_rw("sscratch", `SSCRATCH_ADDR, 32'hFFFF_FFFF);
        check_rw("sepc",     `SEPC_ADDR,     `EPC_MASK);
        check_rw("scause",   `SCAUSE_ADDR,   `CAUSE_MASK);
        check_rw("stval",    `STVAL_ADDR,    32'hFFFF_FFFF);
        end_test("reset and m-mode writes");
    endtask

    task automatic sstatus_view();
        word_t rd;
        word_t m_only;
        test_start_errors = errors;
        // machine-only fields that the sstatus write must not touch
        m_only = (32'h1 << `MSTATUS_MIE) | (32'h1 << `MSTATUS_MPIE) | (32'h3 << `MSTATUS_MPP_LO);
        wb_write(`MSTATUS_ADDR, m_only);
        wb_write(`SSTATUS_ADDR, 32'hFFFF_FFFF);
        wb_read(`SSTATUS_ADDR, rd);
        check_word("sstatus", rd, `SSTATUS_MASK);
        wb_read(`MSTATUS_ADDR, rd);
        check_word("mstatus", rd, m_only | `SSTATUS_MASK);
        check_word("status", status, m_only | `SSTATUS_MASK);
        wb_write(`SSTATUS_ADDR, 32'h0);
        wb_read(`MSTATUS_ADDR, rd);
        check_word("mstatus after sstatus clear", rd, m_only);
        end_test("sstatus view");
    endtask

    task automatic machine_trap();
        word_t data;
        word_t rd;
        word_t pc;
        word_t tv;
        test_start_errors = errors;
        data = rand_bits(`XLEN);
        wb_write(`MTVEC_ADDR, data);
        mtvec_exp = data & `TVEC_MASK;
        wb_write(`MSTATUS_ADDR, 32'h1 << `MSTATUS_MIE);
        pc = rand_bits(`XLEN);
        tv = rand_bits(`XLEN);
        raise_event(EV_TRAP, `CAUSE_ILLEGAL_INST, pc, tv, mtvec_exp);
        check_word("status", status, (32'h1 << `MSTATUS_MPIE) | (32'h3 << `MSTATUS_MPP_LO));
        check_priv(PRIV_M);
        wb_read(`MEPC_ADDR, rd);
        check_word("mepc", rd, pc & `EPC_MASK);
        wb_read(`MCAUSE_ADDR, rd);
        check_word("mcause", rd, {27'b0, `CAUSE_ILLEGAL_INST});
        wb_read(`MTVAL_ADDR, rd);
        check_word("mtval", rd, tv);
        raise_event(EV_MRET, '0, '0, '0, pc & `EPC_MASK);
        check_word("status", status, (32'h1 << `MSTATUS_MIE) | (32'h1 << `MSTATUS_MPIE));
        check_priv(PRIV_M);
        end_test("machine trap and mret");
    endtask

    task automatic delegated_ecall();
        word_t data;
        word_t rd;
        word_t pc;
        word_t stvec_exp;
        word_t mepc_exp;
        test_start_errors = errors;
        wb_write(`MEDELEG_ADDR, 32'h1 << `CAUSE_ECALL_U);
        data = rand_bits(`XLEN);
        wb_write(`STVEC_ADDR, data);
        stvec_exp = data & `TVEC_MASK;
        data = rand_bits(`XLEN);
        wb_write(`MEPC_ADDR, data);
        mepc_exp = data & `EPC_MASK;
        wb_write(`MSTATUS_ADDR, 32'h0);  // mpp = u
        raise_event(EV_MRET, '0, '0, '0, mepc_exp);
        check_priv(PRIV_U);
        pc = rand_bits(`XLEN);
        raise_event(EV_ECALL, '0, pc, rand_bits(`XLEN), stvec_exp);
        check_word("status", status, 32'h1 << `MSTATUS_MPIE);
        check_priv(PRIV_S);
        wb_read(`SCAUSE_ADDR, rd);
        check_word("scause", rd, {27'b0, `CAUSE_ECALL_U});
        wb_read(`SEPC_ADDR, rd);
        check_word("sepc", rd, pc & `EPC_MASK);
        wb_read(`STVAL_ADDR, rd);
        check_word("stval", rd, '0);
        raise_event(EV_SRET, '0, '0, '0, pc & `EPC_MASK);
        check_word("status", status, (32'h1 << `MSTATUS_MPIE) | (32'h1 << `MSTATUS_SPIE));
        check_priv(PRIV_U);
        end_test("delegated ecall from u");
    endtask

    task automatic priv_error();
        word_t data;
        word_t rd;
        word_t scratch;
        word_t mepc_exp;
        logic  got_ack;
        logic  got_err;
        test_start_errors = errors;
        // medeleg bit 2 is clear, so this lands in m
        raise_event(EV_TRAP, `CAUSE_ILLEGAL_INST, rand_bits(`XLEN), rand_bits(`XLEN), mtvec_exp);
        check_priv(PRIV_M);
        scratch = rand_bits(`XLEN);
        wb_write(`MSCRATCH_ADDR, scratch);
        data = rand_bits(`XLEN);
        wb_write(`MEPC_ADDR, data);
        mepc_exp = data & `EPC_MASK;
        wb_write(`MSTATUS_ADDR, 32'h0);
        raise_event(EV_MRET, '0, '0, '0, mepc_exp);
        check_priv(PRIV_U);
        bus_access(1'b0, `MSCRATCH_ADDR, '0, rd, got_ack, got_err);
        if (!got_err || got_ack) begin
            $display("u-mode read of mscratch was not rejected with err");
            errors++;
        end
        check_word("dat_r on err", rd, '0);
        bus_access(1'b1, `MSCRATCH_ADDR, ~scratch, rd, got_ack, got_err);
        if (!got_err || got_ack) begin
            $display("u-mode write of mscratch was not rejected with err");
            errors++;
        end
        bus_access(1'b0, 12'h0C0, '0, rd, got_ack, got_err);  // unknown, u level
        if (!got_ack || got_err) begin
            $display("read of unknown csr 0c0 was not acknowledged");
            errors++;
        end
        check_word("unknown csr 0c0", rd, '0);
        raise_event(EV_TRAP, `CAUSE_ILLEGAL_INST, rand_bits(`XLEN), rand_bits(`XLEN), mtvec_exp);
        check_priv(PRIV_M);
        wb_read(`MSCRATCH_ADDR, rd);
        check_word("mscratch", rd, scratch);
        wb_write(12'h7C0, rand_bits(`XLEN));
        wb_read(12'h7C0, rd);
        check_word("unknown csr 7c0", rd, '0);
        end_test("privilege error and unknown csr");
    endtask

    initial begin
        lfsr_state        = 32'hcce0d169;
        errors            = 0;
        test_start_errors = 0;
        tests_run         = 0;
        tests_failed      = 0;
        mtvec_exp         = '0;
        rst          = 1'b1;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        dat_w        = '0;
        trap_valid   = 1'b0;
        trap_cause   = '0;
        trap_pc      = '0;
        trap_tval_in = '0;
        ecall        = 1'b0;
        mret         = 1'b0;
        sret         = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        reset_and_rw();
        sstatus_view();
        machine_trap();
        delegated_ecall();
        priv_error();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
csr_pkg.sv
csr_bus_port.sv
csr_regs.sv
trap_unit.sv
csr_top.sv
tb_csr_top.sv

/* Makefile */
# verilator build of the csr block testbench
TOP = tb_csr_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee run.log
	grep -q "^Done: no errors$$" run.log

clean:
	rm -rf obj_dir run.log
